// File: hw/pool_pkg.sv
package pool_pkg;

	// Datapath sizing
	localparam int LANES        = 4;                   // Channels pooled in parallel, one atom = LANES words
	localparam int DATA_W       = 16;                  // Sample and result width
	localparam int MAX_WIN_LOG2 = 3;                   // Up to 8 atoms per window
	localparam int ACC_W        = DATA_W + MAX_WIN_LOG2; // Room for a full window sum
	localparam int LANE_IDX_W   = $clog2(LANES);       // Word index inside an atom
	localparam int WIN_CNT_W    = 8;                   // Windows per layer
	localparam int WIN_LOG2_W   = 3;                   // Window exponent field

	// Layer controller states
	localparam int             ST_W      = 2;
	localparam logic [ST_W-1:0] ST_IDLE   = 2'd0;      // Waiting for start
	localparam logic [ST_W-1:0] ST_RUN    = 2'd1;      // Feeding atoms to the lanes
	localparam logic [ST_W-1:0] ST_DRAIN  = 2'd2;      // Window done, handing results to serializer
	localparam logic [ST_W-1:0] ST_FINISH = 2'd3;      // Last window out, waiting for serializer

	// Pooling mode, what is left of the engine op codes
	typedef enum logic {
		POOL_MAX = 1'b0,  // Signed maximum
		POOL_AVG = 1'b1   // Sum then arithmetic shift
	} pool_mode_t;

endpackage

// File: hw/atom_deser.sv
`timescale 1ns/1ps

module atom_deser import pool_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	// Four-phase input stream, slave side
	input  logic                    i_in_req,
	input  logic [DATA_W-1:0]       i_in_data,
	output logic                    o_in_ack,
	// Packed atom towards the lanes
	output logic                    o_atom_valid,
	output logic [LANES*DATA_W-1:0] o_atom,
	input  logic                    i_atom_take
);

	logic [LANE_IDX_W-1:0] word_cnt;  // Words collected in the current atom
	logic                  word_take; // Accept the word on the bus this cycle
	logic                  atom_full; // This word completes the atom

	// New req is held off while a finished atom waits, that is the back-pressure
	assign word_take = i_in_req && !o_in_ack && !o_atom_valid;
	assign atom_full = (word_cnt == LANE_IDX_W'(LANES - 1));

	// Handshake and atom bookkeeping
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_in_ack     <= 1'b0;
			o_atom_valid <= 1'b0;
			word_cnt     <= '0;
		end else begin
			if (i_atom_take)
				o_atom_valid <= 1'b0; // Controller consumed the atom
			if (word_take) begin
				o_in_ack <= 1'b1;
				if (atom_full) begin
					word_cnt     <= '0;
					o_atom_valid <= 1'b1; // Visible the cycle after the last word
				end else begin
					word_cnt <= word_cnt + 1'b1;
				end
			end else if (o_in_ack && !i_in_req) begin
				o_in_ack <= 1'b0; // Master released req, close the cycle
			end
		end
	end

	// Shift in from the top so word k ends up in lane k
	always_ff @(posedge clk) begin
		if (word_take)
			o_atom <= {i_in_data, o_atom[LANES*DATA_W-1:DATA_W]};
	end

endmodule

// File: hw/pool_ctrl.sv
`timescale 1ns/1ps

module pool_ctrl import pool_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	// Layer command
	input  logic                  i_start,
	input  pool_mode_t            i_mode,
	input  logic [WIN_LOG2_W-1:0] i_win_log2,
	input  logic [WIN_CNT_W-1:0]  i_num_windows,
	// Atom intake
	input  logic                  i_atom_valid,
	output logic                  o_atom_take,
	// Lane strobes and configuration
	output logic                  o_lane_load,
	output logic                  o_lane_first,
	output logic                  o_lane_last,
	output pool_mode_t            o_mode,
	output logic [WIN_LOG2_W-1:0] o_win_log2,
	// Serializer
	output logic                  o_ser_load,
	input  logic                  i_ser_busy,
	// Status
	output logic                  o_busy,
	output logic                  o_done
);

	logic [ST_W-1:0]         state;
	logic [MAX_WIN_LOG2-1:0] atom_cnt;  // Atom position inside the window
	logic [WIN_CNT_W-1:0]    win_cnt;   // Window position inside the layer
	logic [WIN_CNT_W-1:0]    num_win_r; // Registered window count
	logic [MAX_WIN_LOG2-1:0] win_mask;  // Index of the last atom in a window
	logic                    take;
	logic                    win_end;
	logic                    layer_end;

	assign win_mask  = MAX_WIN_LOG2'((1 << o_win_log2) - 1);
	assign take      = (state == ST_RUN) && i_atom_valid; // Never while waiting on serializer
	assign win_end   = (atom_cnt == win_mask);
	assign layer_end = (win_cnt == num_win_r - 1'b1);

	assign o_atom_take  = take;
	assign o_lane_load  = take;              // Lanes sample the atom as it is released
	assign o_lane_first = (atom_cnt == '0);
	assign o_lane_last  = win_end;
	assign o_ser_load   = (state == ST_DRAIN) && !i_ser_busy;
	assign o_busy       = (state != ST_IDLE);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state      <= ST_IDLE;
			atom_cnt   <= '0;
			win_cnt    <= '0;
			num_win_r  <= '0;
			o_mode     <= POOL_MAX;
			o_win_log2 <= '0;
			o_done     <= 1'b0;
		end else begin
			o_done <= 1'b0; // Single-cycle pulse
			case (state)
				ST_IDLE: begin
					if (i_start) begin // Latch the layer command
						o_mode     <= i_mode;
						o_win_log2 <= i_win_log2;
						num_win_r  <= i_num_windows;
						atom_cnt   <= '0;
						win_cnt    <= '0;
						state      <= ST_RUN;
					end
				end
				ST_RUN: begin
					if (take) begin
						if (win_end) begin
							atom_cnt <= '0;
							state    <= ST_DRAIN; // Window closes with this atom
						end else begin
							atom_cnt <= atom_cnt + 1'b1;
						end
					end
				end
				ST_DRAIN: begin
					if (!i_ser_busy) begin // ser_load fires in this cycle
						if (layer_end) begin
							state <= ST_FINISH;
						end else begin
							win_cnt <= win_cnt + 1'b1;
							state   <= ST_RUN;
						end
					end
				end
				ST_FINISH: begin
					if (!i_ser_busy) begin // Last word fully acknowledged
						o_done <= 1'b1;
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: hw/pool_lane.sv
`timescale 1ns/1ps

module pool_lane import pool_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  i_load,
	input  logic                  i_first,
	input  logic                  i_last,
	input  pool_mode_t            i_mode,
	input  logic [WIN_LOG2_W-1:0] i_win_log2,
	input  logic [DATA_W-1:0]     i_sample,
	output logic [DATA_W-1:0]     o_result
);

	logic signed [ACC_W-1:0] acc;        // Running max or sum
	logic signed [ACC_W-1:0] acc_next;
	logic signed [ACC_W-1:0] sample_ext; // Sample widened with its sign
	logic signed [ACC_W-1:0] avg;        // Floor of sum / 2^win_log2
	logic [DATA_W-1:0]       res_next;

	assign sample_ext = {{(ACC_W - DATA_W){i_sample[DATA_W-1]}}, i_sample};
	assign avg        = acc_next >>> i_win_log2;
	assign res_next   = (i_mode == POOL_MAX) ? acc_next[DATA_W-1:0] : avg[DATA_W-1:0];

	always_comb begin
		if (i_first)
			acc_next = sample_ext; // Window restarts from the first sample
		else if (i_mode == POOL_MAX)
			acc_next = (sample_ext > acc) ? sample_ext : acc; // Signed compare
		else
			acc_next = acc + sample_ext;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc      <= '0;
			o_result <= '0;
		end else if (i_load) begin
			acc <= acc_next;
			if (i_last)
				o_result <= res_next; // Held until the next window closes
		end
	end

endmodule

// File: hw/result_ser.sv
`timescale 1ns/1ps

module result_ser import pool_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    i_load,
	input  logic [LANES*DATA_W-1:0] i_results,
	output logic                    o_busy,
	// Four-phase output stream, master side
	output logic                    o_out_req,
	output logic [DATA_W-1:0]       o_out_data,
	input  logic                    i_out_ack
);

	logic [LANES*DATA_W-1:0] res_buf;  // Snapshot of all lanes
	logic [LANE_IDX_W-1:0]   idx;      // Word being sent, lane 0 first
	logic                    last_word;

	assign last_word  = (idx == LANE_IDX_W'(LANES - 1));
	assign o_out_data = res_buf[idx*DATA_W +: DATA_W]; // Only moves while req and ack are low

	// Capture once so the lanes can start the next window
	always_ff @(posedge clk) begin
		if (i_load)
			res_buf <= i_results;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_busy    <= 1'b0;
			o_out_req <= 1'b0;
			idx       <= '0;
		end else if (i_load) begin
			o_busy    <= 1'b1;
			o_out_req <= 1'b1; // First word goes straight out
			idx       <= '0;
		end else if (o_busy) begin
			if (o_out_req && i_out_ack) begin
				o_out_req <= 1'b0; // Slave took it
			end else if (!o_out_req && !i_out_ack) begin
				// Previous ack has fallen
				if (last_word) begin
					o_busy <= 1'b0;
				end else begin
					idx       <= idx + 1'b1;
					o_out_req <= 1'b1;
				end
			end
		end
	end

endmodule

// File: hw/pool_engine.sv
`timescale 1ns/1ps

module pool_engine import pool_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	// Command
	input  logic                  i_start,
	input  pool_mode_t            i_mode,
	input  logic [WIN_LOG2_W-1:0] i_win_log2,
	input  logic [WIN_CNT_W-1:0]  i_num_windows,
	// Input stream
	input  logic                  i_in_req,
	input  logic [DATA_W-1:0]     i_in_data,
	output logic                  o_in_ack,
	// Output stream
	output logic                  o_out_req,
	output logic [DATA_W-1:0]     o_out_data,
	input  logic                  i_out_ack,
	// Status
	output logic                  o_busy,
	output logic                  o_done
);

	logic                    atom_valid, atom_take;
	logic [LANES*DATA_W-1:0] atom;      // Lane k in bits k*DATA_W up
	logic [LANES*DATA_W-1:0] results;   // Same layout as atom
	logic                    lane_load, lane_first, lane_last;
	pool_mode_t              mode_r;
	logic [WIN_LOG2_W-1:0]   win_log2_r;
	logic                    ser_load, ser_busy;

	atom_deser u_deser (
		.clk(clk), .rst(rst),
		.i_in_req(i_in_req), .i_in_data(i_in_data), .o_in_ack(o_in_ack),
		.o_atom_valid(atom_valid), .o_atom(atom), .i_atom_take(atom_take)
	);

	pool_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.i_start(i_start), .i_mode(i_mode), .i_win_log2(i_win_log2),
		.i_num_windows(i_num_windows),
		.i_atom_valid(atom_valid), .o_atom_take(atom_take),
		.o_lane_load(lane_load), .o_lane_first(lane_first), .o_lane_last(lane_last),
		.o_mode(mode_r), .o_win_log2(win_log2_r),
		.o_ser_load(ser_load), .i_ser_busy(ser_busy),
		.o_busy(o_busy), .o_done(o_done)
	);

	// One accumulator per channel
	for (genvar g = 0; g < LANES; g++) begin : g_lane
		pool_lane u_lane (
			.clk(clk), .rst(rst),
			.i_load(lane_load), .i_first(lane_first), .i_last(lane_last),
			.i_mode(mode_r), .i_win_log2(win_log2_r),
			.i_sample(atom[g*DATA_W +: DATA_W]),
			.o_result(results[g*DATA_W +: DATA_W])
		);
	end

	result_ser u_ser (
		.clk(clk), .rst(rst),
		.i_load(ser_load), .i_results(results), .o_busy(ser_busy),
		.o_out_req(o_out_req), .o_out_data(o_out_data), .i_out_ack(i_out_ack)
	);

endmodule

// File: sim/pool_ref.svh
`ifndef POOL_REF_SVH
`define POOL_REF_SVH

// Expected result of one lane over one window
// Window words are stored atom after atom, word k of an atom belongs to lane k
function automatic logic [DATA_W-1:0] pool_ref(
	input logic [DATA_W-1:0] win [0:(LANES << MAX_WIN_LOG2)-1],
	input int                lane,
	input pool_mode_t        mode,
	input int                win_log2
);
	int n_atoms;
	int val;
	int best;
	int sum;
	int quo;
	n_atoms = 1 << win_log2;
	best    = -65536; // Below any 16-bit signed sample
	sum     = 0;
	for (int a = 0; a < n_atoms; a++) begin
		val = int'($signed(win[a*LANES + lane]));
		if (val > best)
			best = val;
		sum = sum + val;
	end
	if (mode == POOL_MAX)
		return best[DATA_W-1:0];
	quo = sum / n_atoms; // Division rounds toward zero
	if ((quo * n_atoms != sum) && (sum < 0))
		quo = quo - 1;   // Step down to the floor for negative sums
	return quo[DATA_W-1:0];
endfunction

`endif

// File: sim/tb_pool_engine.sv
`timescale 1ns/1ps

module tb_pool_engine import pool_pkg::*; ();

	localparam int TIMEOUT = 200; // Cycles allowed for any single wait

	// Directed max set with one row per atom
	// Lanes 0..3 hold negative, positive, equal and mixed values
	localparam logic [DATA_W-1:0] MAX_SET [0:15] = '{
		16'hfffb, 16'h0007, 16'h002a, 16'hffff,
		16'hfffd, 16'h012c, 16'h002a, 16'h0000,
		16'hff9c, 16'h7fff, 16'h002a, 16'h0001,
		16'h8000, 16'h0001, 16'h002a, 16'hfffe
	};

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  i_start;
	pool_mode_t            i_mode;
	logic [WIN_LOG2_W-1:0] i_win_log2;
	logic [WIN_CNT_W-1:0]  i_num_windows;
	logic                  i_in_req;
	logic [DATA_W-1:0]     i_in_data;
	logic                  o_in_ack;
	logic                  o_out_req;
	logic [DATA_W-1:0]     o_out_data;
	logic                  i_out_ack;
	logic                  o_busy;
	logic                  o_done;

	int                seed = 69;       // Samples and layer config
	int                ack_seed = 69;   // Output ack delays
	logic [DATA_W-1:0] stim_mem [0:255]; // Whole layer stored window after window
	pool_mode_t        cur_mode;
	int                cur_log2;
	int                out_base;        // out_cnt at layer start
	int                layer_words;     // Words the layer must produce
	int                out_cnt = 0;     // Output words acknowledged so far
	int                done_cnt = 0;    // o_done pulses seen so far

	`include "pool_ref.svh"

	always #5 clk = ~clk;

	pool_engine uut (
		.clk(clk), .rst(rst),
		.i_start(i_start), .i_mode(i_mode), .i_win_log2(i_win_log2),
		.i_num_windows(i_num_windows),
		.i_in_req(i_in_req), .i_in_data(i_in_data), .o_in_ack(o_in_ack),
		.o_out_req(o_out_req), .o_out_data(o_out_data), .i_out_ack(i_out_ack),
		.o_busy(o_busy), .o_done(o_done)
	);

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// One cycle of a wait loop where n counts the cycles already spent
	task automatic tick_or_timeout(input string what, input int n);
		@(negedge clk);
		assert (n < TIMEOUT) else begin
			$display("timeout waiting for %s", what);
			$display(">>> FAIL");
			$fatal(1, "testbench stalled");
		end
	endtask

	// Input master running one full four-phase cycle from a falling edge
	task automatic send_word(input logic [DATA_W-1:0] d);
		int n;
		i_in_data = d;
		i_in_req  = 1'b1;
		n = 0;
		while (!o_in_ack) begin
			tick_or_timeout("o_in_ack to rise", n);
			n++;
		end
		i_in_req = 1'b0;
		n = 0;
		while (o_in_ack) begin
			tick_or_timeout("o_in_ack to fall", n);
			n++;
		end
	endtask

	// Run a layer over stim_mem with an optional stray start in window 2
	task automatic run_layer(input pool_mode_t mode, input int lg, input int nwin,
		input bit mid_start);
		int n;
		int nw;
		int done_base;
		nw          = LANES << lg;
		cur_mode    = mode;
		cur_log2    = lg;
		out_base    = out_cnt;
		layer_words = nwin * LANES;
		done_base   = done_cnt;
		@(negedge clk);
		i_start       = 1'b1;
		i_mode        = mode;
		i_win_log2    = WIN_LOG2_W'(lg);
		i_num_windows = WIN_CNT_W'(nwin);
		@(negedge clk);
		i_start = 1'b0;
		check_val("o_busy", 32'(o_busy), 32'd1);
		for (int i = 0; i < nwin * nw; i++) begin
			if (mid_start && i == 2 * nw) begin
				i_start       = 1'b1; // Must be ignored while busy
				i_mode        = (mode == POOL_MAX) ? POOL_AVG : POOL_MAX;
				i_num_windows = 8'd1;
				@(negedge clk);
				i_start = 1'b0;
			end
			send_word(stim_mem[i]);
		end
		n = 0;
		while (done_cnt == done_base) begin
			tick_or_timeout("o_done", n);
			n++;
		end
		repeat (8) @(negedge clk); // Room for a second pulse or stray words
		check_val("o_done pulses", 32'(done_cnt - done_base), 32'd1);
		check_val("output words", 32'(out_cnt - out_base), 32'(layer_words));
		check_val("o_busy", 32'(o_busy), 32'd0);
	endtask

	// Output responder and comparison
	initial begin : responder
		int                r;
		int                n;
		int                idx;
		int                nw;
		logic [DATA_W-1:0] win_copy [0:(LANES << MAX_WIN_LOG2)-1];
		logic [DATA_W-1:0] exp_word;
		i_out_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (o_out_req && !i_out_ack) begin
				idx = out_cnt - out_base;
				nw  = LANES << cur_log2;
				for (int i = 0; i < nw; i++)
					win_copy[i] = stim_mem[(idx / LANES) * nw + i]; // Window of this word
				exp_word = pool_ref(win_copy, idx % LANES, cur_mode, cur_log2);
				check_val("o_out_data", 32'(o_out_data), 32'(exp_word));
				r = $random(ack_seed);
				repeat (int'(r[2:0]) % 6) @(negedge clk); // 0 to 5 cycles
				i_out_ack = 1'b1;
				n = 0;
				while (o_out_req) begin
					tick_or_timeout("o_out_req to fall", n);
					n++;
				end
				i_out_ack = 1'b0;
				out_cnt++;
			end
		end
	end

	// o_done may only come once every word is through
	always @(negedge clk) begin
		if (o_done) begin
			done_cnt = done_cnt + 1;
			check_val("words before o_done", 32'(out_cnt - out_base), 32'(layer_words));
		end
	end

	initial begin : main
		int         r;
		int         lg;
		pool_mode_t mode;
		rst           = 1'b1;
		i_start       = 1'b0;
		i_mode        = POOL_MAX;
		i_win_log2    = '0;
		i_num_windows = '0;
		i_in_req      = 1'b0;
		i_in_data     = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_val("o_in_ack", 32'(o_in_ack), 32'd0);
		check_val("o_out_req", 32'(o_out_req), 32'd0);
		check_val("o_busy", 32'(o_busy), 32'd0);
		check_val("o_done", 32'(o_done), 32'd0);

		for (int i = 0; i < 16; i++)
			stim_mem[i] = MAX_SET[i];
		run_layer(POOL_MAX, 2, 1, 1'b0);

		for (int i = 0; i < 32; i++) begin // Eight atoms of random signed samples
			r = $random(seed);
			stim_mem[i] = r[DATA_W-1:0];
		end
		run_layer(POOL_AVG, 3, 1, 1'b0);

		// Six-window layers over every exponent with back-pressure from slow acks
		for (int l = 0; l < 4; l++) begin
			r    = $random(seed);
			mode = r[0] ? POOL_AVG : POOL_MAX;
			lg   = l;
			for (int i = 0; i < 6 * (LANES << lg); i++) begin
				r = $random(seed);
				stim_mem[i] = r[DATA_W-1:0];
			end
			run_layer(mode, lg, 6, 1'b1);
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: all.f
+incdir+sim
hw/pool_pkg.sv
hw/atom_deser.sv
hw/pool_ctrl.sv
hw/pool_lane.sv
hw/result_ser.sv
hw/pool_engine.sv
sim/tb_pool_engine.sv

// File: run.sh
#!/bin/sh
# Build and run the pool engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tb_pool_engine \
	-o tb_pool_engine || { echo "build failed"; exit 1; }
./obj_dir/tb_pool_engine > sim.log 2>&1
grep -q '>>> FAIL' sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q '>>> PASS' sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"
